// File: testbench/share_vectors.txt
# mode(0 single, 1 pair: main line then sub line) port(0 main, 1 sub) write addr strb
# wdata exp_rdata exp_err dma_hold; addr strb wdata exp_rdata in hex, others decimal
0 0 1 005 3 1234 0000 0 0
0 0 0 005 0 0000 1234 0 0
0 1 1 006 3 abcd 0000 0 0
0 1 0 006 0 0000 abcd 0 0
0 1 0 005 0 0000 1234 0 0
0 0 0 006 0 0000 abcd 0 0
# byte lanes
0 0 1 020 3 a5c3 0000 0 0
0 0 1 020 1 0077 0000 0 0
0 0 0 020 0 0000 a577 0 0
0 1 1 020 2 1e00 0000 0 0
0 1 0 020 0 0000 1e77 0 0
# window error, 310 and 300 lie above the implemented words
0 0 1 010 3 0f0f 0000 0 0
0 1 1 310 3 dead 0000 1 0
0 0 0 300 0 0000 0000 1 0
0 0 0 010 0 0000 0f0f 0 0
# both ports at once
1 0 1 040 3 aaaa 0000 0 0
1 1 1 040 3 5555 0000 0 0
0 1 0 040 0 0000 aaaa 0 0
1 0 0 005 0 0000 1234 0 0
1 1 0 006 0 0000 abcd 0 0
# sub locked out by the object DMA
1 0 1 041 3 7e57 0000 0 0
1 1 0 020 0 0000 1e77 0 8
0 1 0 041 0 0000 7e57 0 0

// File: compile.f
source/share_pkg.sv
source/share_req_if.sv
source/apb_bus_port.sv
source/video_share.sv
source/twin_share_top.sv
testbench/twin_share_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the shared video RAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module twin_share_tb \
    -f compile.f \
    -o twin_share_sim

./obj_dir/twin_share_sim

// File: testbench/twin_share_tb.sv
`timescale 1ns/1ns
/*
 * testbench for the dual-CPU shared video RAM
 * replays the vector file on the main and sub APB ports
 */
module twin_share_tb import share_pkg::*; ();

    localparam int ADDR_W     = 10;
    localparam int RAM_WORDS  = 768;
    localparam int FILL_BASE  = 'h2f0;
    localparam int FILL_WORDS = 2;

    typedef struct packed {
        int                mode;
        int                port;
        bit                wr;
        logic [ADDR_W-1:0] addr;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] rdata;
        bit                err;
        int                hold;
    } vec_t;

    logic              clk;
    logic              arst_n;
    logic              dma_bsy;
    // index 0 is the main CPU, index 1 the sub CPU
    logic              psel    [2];
    logic              penable [2];
    logic              pwrite  [2];
    logic [ADDR_W-1:0] paddr   [2];
    logic [strb_w-1:0] pstrb   [2];
    logic [data_w-1:0] pwdata  [2];
    logic [data_w-1:0] prdata  [2];
    logic              pready  [2];
    logic              pslverr [2];

    vec_t              vecs[$];
    logic [data_w-1:0] model_mem [RAM_WORDS];
    slot_owner_t       slot_seen;
    bit                main_done;
    int                seed = 30;
    int                cycle_cnt = 0;
    int                cycle_limit = 0;

    twin_share_top i_twin_share_top (
        .clk          ( clk        ),
        .arst_n       ( arst_n     ),
        .dma_bsy      ( dma_bsy    ),
        .main_psel    ( psel[0]    ),
        .main_penable ( penable[0] ),
        .main_pwrite  ( pwrite[0]  ),
        .main_paddr   ( paddr[0]   ),
        .main_pstrb   ( pstrb[0]   ),
        .main_pwdata  ( pwdata[0]  ),
        .main_prdata  ( prdata[0]  ),
        .main_pready  ( pready[0]  ),
        .main_pslverr ( pslverr[0] ),
        .sub_psel     ( psel[1]    ),
        .sub_penable  ( penable[1] ),
        .sub_pwrite   ( pwrite[1]  ),
        .sub_paddr    ( paddr[1]   ),
        .sub_pstrb    ( pstrb[1]   ),
        .sub_pwdata   ( pwdata[1]  ),
        .sub_prdata   ( prdata[1]  ),
        .sub_pready   ( pready[1]  ),
        .sub_pslverr  ( pslverr[1] )
    );

    always #20 clk = ~clk;

    // slot owner as the arbiter rule gives it, main first after reset
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_seen <= main_slot;
        end else begin
            slot_seen <= (slot_seen == main_slot) ? sub_slot : main_slot;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_with_failure($sformatf("timeout, a transfer never completed in %0d cycles",
                                        cycle_limit));
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic string mismatch_line(input string msg);
        return $sformatf("mismatch at %0t ns: %s", $time, msg);
    endfunction

    // old word with the strobed byte lanes replaced
    function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old_word,
                                                      input logic [data_w-1:0] new_word,
                                                      input logic [strb_w-1:0] strb);
        logic [data_w-1:0] word;
        word = old_word;
        for (int i = 0; i < strb_w; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return word;
    endfunction

    // file expectations must follow from the write history
    task automatic cross_check(input vec_t v, input int idx);
        bit out_of_window;
        out_of_window = int'(v.addr) >= RAM_WORDS;
        assert (v.err == out_of_window) else
            stop_with_failure($sformatf("vector %0d has an error flag that does not fit its address",
                                        idx));
        if (!v.err && v.wr) begin
            model_mem[v.addr] = merge_lanes(model_mem[v.addr], v.wdata, v.strb);
        end else if (!v.err) begin
            assert (v.rdata == model_mem[v.addr]) else
                stop_with_failure($sformatf("vector %0d expects data the earlier writes do not give",
                                            idx));
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        int    f_mode, f_port, f_wr, f_addr, f_strb, f_wdata, f_rdata, f_err, f_hold;
        vec_t  v;
        fd = $fopen("testbench/share_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("the vector file testbench/share_vectors.txt could not be opened");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %h %h %h %h %d %d", f_mode, f_port, f_wr, f_addr,
                            f_strb, f_wdata, f_rdata, f_err, f_hold);
                if (n != 9) begin
                    stop_with_failure($sformatf("the vector file has a malformed line: %s", line));
                end
                v.mode  = f_mode;
                v.port  = f_port;
                v.wr    = (f_wr != 0);
                v.addr  = f_addr[ADDR_W-1:0];
                v.strb  = f_strb[strb_w-1:0];
                v.wdata = f_wdata[data_w-1:0];
                v.rdata = f_rdata[data_w-1:0];
                v.err   = (f_err != 0);
                v.hold  = f_hold;
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // one APB transfer, started at a falling edge
    task automatic run_transfer(input vec_t v);
        int p;
        p          = v.port;
        psel[p]    = 1'b1;
        pwrite[p]  = v.wr;
        paddr[p]   = v.addr;
        pstrb[p]   = v.strb;
        pwdata[p]  = v.wdata;
        @(negedge clk);
        penable[p] = 1'b1;
        do begin
            @(negedge clk);
        end while (!pready[p]);
        psel[p]    = 1'b0;
        penable[p] = 1'b0;
        if (p == 0) begin
            main_done = 1'b1;
        end
        assert (pslverr[p] == v.err) else
            stop_with_failure(mismatch_line($sformatf("port %0d addr %h pslverr %b expected %b",
                                                      p, v.addr, pslverr[p], v.err)));
        if (!v.wr && !v.err) begin
            assert (prdata[p] == v.rdata) else
                stop_with_failure(mismatch_line($sformatf("port %0d addr %h read %h expected %h",
                                                          p, v.addr, prdata[p], v.rdata)));
        end
    endtask

    // object buffer DMA locks the sub port out for a number of cycles
    task automatic hold_dma(input int cycles);
        if (cycles > 0) begin
            dma_bsy = 1'b1;
            repeat (cycles) begin
                @(negedge clk);
                assert (!pready[1]) else
                    stop_with_failure(mismatch_line("sub pready rose while dma_bsy was high"));
            end
            assert (main_done) else
                stop_with_failure("the main transfer did not finish while dma_bsy was high");
            dma_bsy = 1'b0;
        end
    endtask

    initial begin
        int   i;
        int   rnd;
        int   hold;
        int   hold_total;
        vec_t a;
        vec_t b;
        clk        = 1'b0;
        arst_n     = 1'b0;
        dma_bsy    = 1'b0;
        main_done  = 1'b0;
        hold_total = 0;
        for (int p = 0; p < 2; p++) begin
            psel[p]    = 1'b0;
            penable[p] = 1'b0;
            pwrite[p]  = 1'b0;
            paddr[p]   = '0;
            pstrb[p]   = '0;
            pwdata[p]  = '0;
        end
        // filler words that no vector reads back
        for (int k = 0; k < FILL_WORDS; k++) begin
            rnd     = $random(seed);
            a       = '0;
            a.wr    = 1'b1;
            a.addr  = ADDR_W'(FILL_BASE + k);
            a.strb  = '1;
            a.wdata = rnd[data_w-1:0];
            vecs.push_back(a);
        end
        load_vectors();
        i = 0;
        while (i < vecs.size()) begin
            hold_total = hold_total + vecs[i].hold;
            if (vecs[i].mode == 1) begin
                assert (i + 1 < vecs.size() && vecs[i+1].mode == 1 && vecs[i].port == 0 &&
                        vecs[i+1].port == 1) else
                    stop_with_failure($sformatf("vector %0d starts a pair without a sub line", i));
                // sub owns the first slot of a pair, main lands last
                cross_check(vecs[i+1], i + 1);
                cross_check(vecs[i], i);
                hold_total = hold_total + vecs[i+1].hold;
                i = i + 2;
            end else begin
                cross_check(vecs[i], i);
                i = i + 1;
            end
        end
        cycle_limit = 3 + 4 + 8 * vecs.size() + hold_total;

        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            assert (!pready[0] && !pready[1] && !pslverr[0] && !pslverr[1]) else
                stop_with_failure(mismatch_line("pready or pslverr high after reset"));
        end

        i = 0;
        while (i < vecs.size()) begin
            @(negedge clk);
            if (vecs[i].mode == 1) begin
                a    = vecs[i];
                b    = vecs[i+1];
                hold = (a.hold > b.hold) ? a.hold : b.hold;
                if (slot_seen == main_slot) begin
                    @(negedge clk);
                end
                main_done = 1'b0;
                fork
                    run_transfer(a);
                    run_transfer(b);
                    hold_dma(hold);
                join
                i = i + 2;
            end else begin
                run_transfer(vecs[i]);
                i = i + 1;
            end
        end
        repeat (2) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: source/twin_share_top.sv
`timescale 1ns/1ns
/*
 * dual-CPU shared video RAM
 * main and sub APB ports feeding one slot-arbitrated memory
 */
module twin_share_top import share_pkg::*; #(
    parameter int ADDR_W    = 10,
    parameter int RAM_WORDS = 768
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dma_bsy,
    // main CPU
    input  logic              main_psel,
    input  logic              main_penable,
    input  logic              main_pwrite,
    input  logic [ADDR_W-1:0] main_paddr,
    input  logic [strb_w-1:0] main_pstrb,
    input  logic [data_w-1:0] main_pwdata,
    output logic [data_w-1:0] main_prdata,
    output logic              main_pready,
    output logic              main_pslverr,
    // sub CPU
    input  logic              sub_psel,
    input  logic              sub_penable,
    input  logic              sub_pwrite,
    input  logic [ADDR_W-1:0] sub_paddr,
    input  logic [strb_w-1:0] sub_pstrb,
    input  logic [data_w-1:0] sub_pwdata,
    output logic [data_w-1:0] sub_prdata,
    output logic              sub_pready,
    output logic              sub_pslverr
);

    share_req_if #(.ADDR_W(ADDR_W)) main_bus ();
    share_req_if #(.ADDR_W(ADDR_W)) sub_bus ();

    apb_bus_port #(
        .ADDR_W    ( ADDR_W       ),
        .RAM_WORDS ( RAM_WORDS    )
    ) u_main_port (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .psel      ( main_psel    ),
        .penable   ( main_penable ),
        .pwrite    ( main_pwrite  ),
        .paddr     ( main_paddr   ),
        .pstrb     ( main_pstrb   ),
        .pwdata    ( main_pwdata  ),
        .prdata    ( main_prdata  ),
        .pready    ( main_pready  ),
        .pslverr   ( main_pslverr ),
        .bus       ( main_bus     )
    );

    apb_bus_port #(
        .ADDR_W    ( ADDR_W       ),
        .RAM_WORDS ( RAM_WORDS    )
    ) u_sub_port (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .psel      ( sub_psel     ),
        .penable   ( sub_penable  ),
        .pwrite    ( sub_pwrite   ),
        .paddr     ( sub_paddr    ),
        .pstrb     ( sub_pstrb    ),
        .pwdata    ( sub_pwdata   ),
        .prdata    ( sub_prdata   ),
        .pready    ( sub_pready   ),
        .pslverr   ( sub_pslverr  ),
        .bus       ( sub_bus      )
    );

    video_share #(
        .ADDR_W    ( ADDR_W       ),
        .RAM_WORDS ( RAM_WORDS    )
    ) u_share (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .dma_bsy   ( dma_bsy      ),
        .main_bus  ( main_bus     ),
        .sub_bus   ( sub_bus      )
    );

endmodule

// File: source/video_share.sv
`timescale 1ns/1ns
/*
 * shared video RAM with a two-slot arbiter
 * main and sub ports alternate every clock, the sub port is
 * locked out while the object buffer DMA is busy
 */
module video_share import share_pkg::*; #(
    parameter int ADDR_W    = 10,
    parameter int RAM_WORDS = 768
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          dma_bsy,
    share_req_if.arbiter  main_bus,
    share_req_if.arbiter  sub_bus
);

    localparam int lane_w = data_w / strb_w;

    slot_owner_t       slot;
    logic [data_w-1:0] mem [RAM_WORDS];

    logic              main_take;
    logic              sub_take;
    logic              sel_write;
    logic              sel_we;
    logic [ADDR_W-1:0] sel_addr;
    logic [strb_w-1:0] sel_strb;
    logic [data_w-1:0] sel_wdata;

    // slot owner flips every clock, main first
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot <= main_slot;
        end else if (slot == main_slot) begin
            slot <= sub_slot;
        end else begin
            slot <= main_slot;
        end
    end

    assign main_take = main_bus.req && (slot == main_slot);
    // sub CPU has no access while the object buffer is set up
    assign sub_take  = sub_bus.req && (slot == sub_slot) && !dma_bsy;

    assign main_bus.gnt = main_take;
    assign sub_bus.gnt  = sub_take;

    // at most one port is taken, pick its payload
    always_comb begin
        if (sub_take) begin
            sel_we    = sub_bus.we;
            sel_addr  = sub_bus.addr;
            sel_strb  = sub_bus.wstrb;
            sel_wdata = sub_bus.wdata;
        end else begin
            sel_we    = main_bus.we;
            sel_addr  = main_bus.addr;
            sel_strb  = main_bus.wstrb;
            sel_wdata = main_bus.wdata;
        end
    end

    assign sel_write = (main_take || sub_take) && sel_we;

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (sel_write) begin
            for (int i = 0; i < strb_w; i++) begin
                if (sel_strb[i]) begin
                    mem[sel_addr][i*lane_w +: lane_w] <= sel_wdata[i*lane_w +: lane_w];
                end
            end
        end
    end

    // read word shows up in the gnt cycle
    assign main_bus.rdata = main_take ? mem[main_bus.addr] : '0;
    assign sub_bus.rdata  = sub_take ? mem[sub_bus.addr] : '0;

    // a waiting main request keeps its payload until its slot comes
    a_main_hold: assert property (@(posedge clk) disable iff (!arst_n)
        main_bus.req && !main_bus.gnt |=> main_bus.req && $stable(main_bus.we) &&
            $stable(main_bus.addr) && $stable(main_bus.wstrb) && $stable(main_bus.wdata));

    // a sub request held off by the DMA lockout waits with its payload intact
    a_sub_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sub_bus.req && !sub_bus.gnt |=> sub_bus.req && $stable(sub_bus.we) &&
            $stable(sub_bus.addr) && $stable(sub_bus.wstrb) && $stable(sub_bus.wdata));

endmodule

// File: source/apb_bus_port.sv
`timescale 1ns/1ns
/*
 * APB slave port for one CPU
 * checks the address window at access start and turns each
 * in-window transfer into a single request to the arbiter
 */
module apb_bus_port import share_pkg::*; #(
    parameter int ADDR_W    = 10,
    parameter int RAM_WORDS = 768
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [strb_w-1:0] pstrb,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    share_req_if.requester    bus
);

    typedef enum logic [1:0] {
        idle,
        requesting,
        respond
    } port_state_t;

    port_state_t state;
    logic        access_start;
    logic        in_window;
    logic        granted;

    // first cycle of the access phase
    assign access_start = psel && penable && (state == idle);
    assign in_window    = int'(paddr) < RAM_WORDS;
    assign granted      = (state == requesting) && bus.gnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            bus.req <= 1'b0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (access_start) begin
                        if (in_window) begin
                            bus.req <= 1'b1;
                            state   <= requesting;
                        end else begin
                            // outside the window, answer at once with an error
                            pready  <= 1'b1;
                            pslverr <= 1'b1;
                            state   <= respond;
                        end
                    end
                end
                requesting: begin
                    // wait here as long as the arbiter holds us off
                    if (bus.gnt) begin
                        bus.req <= 1'b0;
                        pready  <= 1'b1;
                        pslverr <= 1'b0;
                        state   <= respond;
                    end
                end
                respond: begin
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                    state   <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // payload into the link, read data back out
    always_ff @(posedge clk) begin
        if (access_start && in_window) begin
            bus.we    <= pwrite;
            bus.addr  <= paddr;
            bus.wstrb <= pstrb;
            bus.wdata <= pwdata;
        end
        if (granted && !bus.we) begin
            prdata <= bus.rdata;
        end
    end

    // master keeps address and direction until the slave answers
    a_apb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwrite));

    // the arbiter only grants a raised request
    a_gnt_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        bus.gnt |-> bus.req);

endmodule

// File: source/share_req_if.sv
`timescale 1ns/1ns
/*
 * request/grant link between a bus port and the video RAM arbiter
 * req and payload held until gnt, gnt is a one-cycle pulse
 */
interface share_req_if import share_pkg::*; #(
    parameter int ADDR_W = 10
) ();

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [strb_w-1:0] wstrb;
    logic [data_w-1:0] wdata;
    logic              gnt;
    // valid in the gnt cycle only
    logic [data_w-1:0] rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wstrb,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wstrb,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

// File: source/share_pkg.sv
/*
 * shared video RAM definitions
 * bus word size, byte lanes and the arbiter slot owner
 */
package share_pkg;

    // one CPU bus word
    localparam int data_w = 16;

    // byte lanes per word, one pstrb bit each
    localparam int strb_w = 2;

    // which port owns the current memory slot
    typedef enum logic {
        main_slot,
        sub_slot
    } slot_owner_t;

endpackage
